/* multitap_top.f */
src/multitap_pkg.sv
src/key_strobe_sync.sv
src/keypad_fsm.sv
src/word_assembler.sv
src/axil_word_regs.sv
src/multitap_top.sv
tb/clk_gen.sv
tb/multitap_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the multitap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module multitap_tb -f multitap_top.f -o multitap_sim

# The simulator exits non-zero on $fatal, so keep going and let the search decide
out=$(./obj_dir/multitap_sim) || true
echo "$out"
echo "$out" | grep -q -F '*** PASSED ***'

/* tb/multitap_tb.sv */
`timescale 1ns/1ps

module multitap_tb;

  localparam int n_ch           = 4;
  localparam int timeout_cycles = 20000; // About 4x the worst case of all presses and polls

  localparam logic [7:0] letter_keys [8] = '{multitap_pkg::key_2, multitap_pkg::key_3,
                                             multitap_pkg::key_4, multitap_pkg::key_5,
                                             multitap_pkg::key_6, multitap_pkg::key_7,
                                             multitap_pkg::key_8, multitap_pkg::key_9};
  localparam logic [7:0] dead_keys [4] = '{multitap_pkg::key_1, multitap_pkg::key_a,
                                           multitap_pkg::key_b, multitap_pkg::key_d};

  logic                    clk;
  logic                    nRst;
  logic [n_ch-1:0][7:0]    key_raw;
  multitap_pkg::axil_req_t s_axil;
  multitap_pkg::axil_rsp_t s_axil_rsp;
  integer                  seed;
  int                      cycle_cnt = 0;

  // Reference model per channel with tap count 0 as idle
  int          tap_cnt [n_ch];
  logic [7:0]  last_letter_key [n_ch];
  logic [7:0]  pend_letter [n_ch];
  logic [63:0] work_word [n_ch];
  logic [3:0]  work_len [n_ch];
  logic [63:0] commit_word [n_ch];
  logic [3:0]  commit_len [n_ch];
  logic        exp_valid [n_ch];
  logic        exp_over [n_ch];

  clk_gen i_clk_gen (.clk(clk));

  multitap_top #(.n_ch(n_ch)) i_multitap_top (
    .clk        (clk),
    .nRst       (nRst),
    .key_raw    (key_raw),
    .s_axil     (s_axil),
    .s_axil_rsp (s_axil_rsp)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % 32'(hi - lo + 1));
  endfunction

  // Letters printed on each key
  function automatic string key_letters(input logic [7:0] code);
    case (code)
      multitap_pkg::key_2: return "ABC";
      multitap_pkg::key_3: return "DEF";
      multitap_pkg::key_4: return "GHI";
      multitap_pkg::key_5: return "JKL";
      multitap_pkg::key_6: return "MNO";
      multitap_pkg::key_7: return "PQRS";
      multitap_pkg::key_8: return "TUV";
      multitap_pkg::key_9: return "WXYZ";
      default:             return "";
    endcase
  endfunction

  function automatic logic [31:0] status_exp(input int ch);
    return {20'd0, commit_len[ch], 6'd0, exp_over[ch], exp_valid[ch]};
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch");
    end
  endtask

  task automatic model_press(input int ch, input logic [7:0] code);
    string letters;
    letters = key_letters(code);
    if (letters.len() != 0) begin
      if ((code == last_letter_key[ch]) && (tap_cnt[ch] != 0)) begin
        tap_cnt[ch] = (tap_cnt[ch] == letters.len()) ? 1 : tap_cnt[ch] + 1; // Wrap
      end else begin
        tap_cnt[ch] = 1;
      end
      last_letter_key[ch] = code;
      pend_letter[ch]     = letters[tap_cnt[ch] - 1];
    end else begin
      case (code)
        multitap_pkg::key_submit_letter: begin
          if (tap_cnt[ch] != 0) begin
            if (work_len[ch] < 4'd8) begin // Ninth letter onwards is dropped
              work_word[ch][{work_len[ch][2:0], 3'b000} +: 8] = pend_letter[ch];
              work_len[ch] = work_len[ch] + 4'd1;
            end
            tap_cnt[ch]     = 0;
            pend_letter[ch] = 8'h5F;
          end
        end
        multitap_pkg::key_clear: begin
          tap_cnt[ch]     = 0;
          pend_letter[ch] = 8'h5F;
        end
        multitap_pkg::key_submit_word: begin
          commit_word[ch] = work_word[ch];
          commit_len[ch]  = work_len[ch];
          exp_valid[ch]   = 1'b1;
          work_word[ch]   = '0;
          work_len[ch]    = 4'd0;
          tap_cnt[ch]     = 0;
          pend_letter[ch] = 8'h00;
        end
        multitap_pkg::key_game_end: begin
          work_word[ch]   = '0;
          work_len[ch]    = 4'd0;
          exp_over[ch]    = 1'b1;
          tap_cnt[ch]     = 0;
          pend_letter[ch] = 8'h00;
        end
        default: ; // Dead keys
      endcase
    end
  endtask

  // Entered and left at 2 ns after a rising edge
  task automatic press_key(input int ch, input logic [7:0] code);
    int hold;
    int gap;
    hold = rand_range(3, 6);
    gap  = rand_range(2, 4);
    key_raw[ch] = code;
    model_press(ch, code);
    repeat (hold) @(posedge clk);
    #2;
    key_raw[ch] = 8'h00;
    repeat (gap) @(posedge clk);
    #2;
  endtask

  task automatic enter_letter(input int ch, input logic [7:0] code, input int taps);
    repeat (taps) press_key(ch, code);
    press_key(ch, multitap_pkg::key_submit_letter);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    s_axil.awaddr  = addr;
    s_axil.awvalid = 1'b1;
    s_axil.wdata   = data;
    s_axil.wstrb   = strb;
    s_axil.wvalid  = 1'b1;
    @(negedge clk);
    while (!s_axil_rsp.awready) @(negedge clk);
    check_equal(32'(s_axil_rsp.wready), 32'd1, "wready together with awready");
    @(posedge clk);
    #2;
    s_axil.awvalid = 1'b0;
    s_axil.wvalid  = 1'b0;
    s_axil.bready  = 1'b1;
    @(negedge clk);
    while (!s_axil_rsp.bvalid) @(negedge clk);
    check_equal(32'(s_axil_rsp.bresp), 32'd0, "bresp");
    @(posedge clk);
    #2;
    s_axil.bready = 1'b0;
    // Write-1-to-clear on a mapped status register
    if ((addr[3:0] == 4'd0) && (int'(addr[7:4]) < n_ch) && strb[0]) begin
      if (data[0]) exp_valid[addr[7:4]] = 1'b0;
      if (data[1]) exp_over[addr[7:4]] = 1'b0;
    end
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    int stall;
    s_axil.araddr  = addr;
    s_axil.arvalid = 1'b1;
    @(negedge clk);
    while (!s_axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    #2;
    s_axil.arvalid = 1'b0;
    @(negedge clk);
    while (!s_axil_rsp.rvalid) @(negedge clk);
    data = s_axil_rsp.rdata;
    check_equal(32'(s_axil_rsp.rresp), 32'd0, "rresp");
    stall = rand_range(0, 4);
    repeat (stall) begin // Response must hold while rready is low
      @(negedge clk);
      check_equal(32'(s_axil_rsp.rvalid), 32'd1, "rvalid during stall");
      check_equal(s_axil_rsp.rdata, data, "rdata during stall");
    end
    @(posedge clk);
    #2;
    s_axil.rready = 1'b1;
    @(posedge clk);
    #2;
    s_axil.rready = 1'b0;
  endtask

  // Poll until committed, compare, then clear word_valid
  task automatic verify_word(input int ch);
    logic [7:0]  base;
    logic [31:0] data;
    base = 8'(ch * 16);
    read_reg(base + multitap_pkg::reg_status, data);
    while (!data[0]) read_reg(base + multitap_pkg::reg_status, data);
    check_equal(data, status_exp(ch), "status after submit word");
    read_reg(base + multitap_pkg::reg_word_lo, data);
    check_equal(data, commit_word[ch][31:0], "word low");
    read_reg(base + multitap_pkg::reg_word_hi, data);
    check_equal(data, commit_word[ch][63:32], "word high");
    write_reg(base + multitap_pkg::reg_status, 32'h1, 4'h1);
    read_reg(base + multitap_pkg::reg_status, data);
    check_equal(data, status_exp(ch), "status after word_valid clear");
  endtask

  initial begin
    int          ch;
    int          sel;
    logic [7:0]  code;
    logic [31:0] data;

    seed    = 32'h8815;
    nRst    = 1'b0;
    key_raw = '0;
    s_axil  = '0;
    for (int i = 0; i < n_ch; i++) begin
      tap_cnt[i]         = 0;
      last_letter_key[i] = 8'h00;
      pend_letter[i]     = 8'h5F;
      work_word[i]       = '0;
      work_len[i]        = 4'd0;
      commit_word[i]     = '0;
      commit_len[i]      = 4'd0;
      exp_valid[i]       = 1'b0;
      exp_over[i]        = 1'b0;
    end
    repeat (10) @(posedge clk);
    #2;
    nRst = 1'b1;
    @(posedge clk);
    #2;
    check_equal(32'(s_axil_rsp.arready), 32'd1, "arready after reset");
    check_equal(32'(s_axil_rsp.bvalid), 32'd0, "bvalid after reset");
    read_reg(multitap_pkg::reg_status, data);
    check_equal(data, 32'd0, "status after reset");

    // Tap cycling with wrap and a restart on a key change
    enter_letter(0, multitap_pkg::key_2, 2);
    enter_letter(0, multitap_pkg::key_7, 4);
    enter_letter(0, multitap_pkg::key_9, 5);
    enter_letter(0, multitap_pkg::key_2, 4);
    press_key(0, multitap_pkg::key_2);
    press_key(0, multitap_pkg::key_2);
    enter_letter(0, multitap_pkg::key_3, 1);
    press_key(0, multitap_pkg::key_submit_word);
    verify_word(0);
    check_equal(commit_word[0][31:0], 32'h4157_5342, "BSWA");
    check_equal(commit_word[0][63:32], 32'h0000_0044, "D");

    // Clear, submit from idle and dead keys add nothing
    press_key(1, multitap_pkg::key_4);
    press_key(1, multitap_pkg::key_clear);
    press_key(1, multitap_pkg::key_submit_letter);
    for (int i = 0; i < 4; i++) press_key(1, dead_keys[i]);
    press_key(1, multitap_pkg::key_5);
    press_key(1, multitap_pkg::key_d);
    enter_letter(1, multitap_pkg::key_5, 1); // Dead key left the tap count alone
    press_key(1, multitap_pkg::key_submit_word);
    verify_word(1);
    check_equal(commit_word[1][31:0], 32'h4B, "single K");

    // Game end, then clear each flag on its own
    enter_letter(2, multitap_pkg::key_6, 1);
    press_key(2, multitap_pkg::key_game_end);
    read_reg(8'h20, data);
    while (!data[1]) read_reg(8'h20, data);
    check_equal(data, status_exp(2), "status after game end");
    write_reg(8'h60, 32'h3, 4'hF); // Channel 6 shares its low index bits with channel 2
    write_reg(8'h2C, 32'h3, 4'hF);
    read_reg(8'h20, data);
    check_equal(data, status_exp(2), "status after unmapped writes");
    write_reg(8'h20, 32'h2, 4'h0);
    read_reg(8'h20, data);
    check_equal(data, status_exp(2), "status after write without strobe");
    write_reg(8'h20, 32'h2, 4'h1);
    read_reg(8'h20, data);
    check_equal(data, status_exp(2), "status after game_over clear");
    enter_letter(2, multitap_pkg::key_8, 1);
    press_key(2, multitap_pkg::key_submit_word);
    verify_word(2);

    // Overflow past eight letters
    repeat (10) enter_letter(3, letter_keys[rand_range(0, 7)], rand_range(1, 3));
    press_key(3, multitap_pkg::key_submit_word);
    verify_word(3);
    check_equal(32'(commit_len[3]), 32'd8, "length capped");

    // Unmapped reads
    read_reg(8'h0C, data);
    check_equal(data, 32'd0, "unmapped offset");
    read_reg(8'h40, data);
    check_equal(data, 32'd0, "channel past the last");
    read_reg(8'hF8, data);
    check_equal(data, 32'd0, "top of address space");

    // Random presses interleaved over channels
    repeat (4) begin
      repeat (30) begin
        ch  = rand_range(0, n_ch - 1);
        sel = rand_range(0, 19);
        if (sel < 11) code = letter_keys[rand_range(0, 7)];
        else if (sel < 16) code = multitap_pkg::key_submit_letter;
        else if (sel == 16) code = multitap_pkg::key_clear;
        else code = dead_keys[rand_range(0, 3)];
        press_key(ch, code);
      end
      for (int i = 0; i < n_ch; i++) begin
        press_key(i, multitap_pkg::key_submit_word);
        verify_word(i);
      end
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
  parameter int half_period = 10 // 20 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

/* src/multitap_top.sv */
`timescale 1ns/1ps

module multitap_top #(
  parameter int n_ch = 4
) (
  input  logic                    clk,
  input  logic                    nRst,
  input  logic [n_ch-1:0][7:0]    key_raw,    // Asynchronous, one byte per keypad
  input  multitap_pkg::axil_req_t s_axil,
  output multitap_pkg::axil_rsp_t s_axil_rsp
);

  multitap_pkg::key_event_t  [n_ch-1:0] key_evt;
  multitap_pkg::keypad_out_t [n_ch-1:0] kp_out;
  logic [n_ch-1:0][63:0]                word;
  logic [n_ch-1:0][3:0]                 word_len;
  logic [n_ch-1:0]                      word_valid;
  logic [n_ch-1:0]                      game_over;
  logic [n_ch-1:0]                      clr_word;
  logic [n_ch-1:0]                      clr_game;

  key_strobe_sync #(.n_ch(n_ch)) i_key_strobe_sync (
    .clk     (clk),
    .nRst    (nRst),
    .key_raw (key_raw),
    .key_evt (key_evt)
  );

  // One decoder per keypad
  for (genvar i = 0; i < n_ch; i++) begin : g_ch
    keypad_fsm i_keypad_fsm (
      .clk     (clk),
      .nRst    (nRst),
      .key_evt (key_evt[i]),
      .kp_out  (kp_out[i])
    );
  end

  word_assembler #(.n_ch(n_ch)) i_word_assembler (
    .clk        (clk),
    .nRst       (nRst),
    .kp_out     (kp_out),
    .clr_word   (clr_word),
    .clr_game   (clr_game),
    .word       (word),
    .word_len   (word_len),
    .word_valid (word_valid),
    .game_over  (game_over)
  );

  axil_word_regs #(.n_ch(n_ch)) i_axil_word_regs (
    .clk        (clk),
    .nRst       (nRst),
    .s_axil     (s_axil),
    .s_axil_rsp (s_axil_rsp),
    .word       (word),
    .word_len   (word_len),
    .word_valid (word_valid),
    .game_over  (game_over),
    .clr_word   (clr_word),
    .clr_game   (clr_game)
  );

endmodule

/* src/axil_word_regs.sv */
`timescale 1ns/1ps

module axil_word_regs #(
  parameter int n_ch = 4
) (
  input  logic                    clk,
  input  logic                    nRst,
  input  multitap_pkg::axil_req_t s_axil,
  output multitap_pkg::axil_rsp_t s_axil_rsp,
  input  logic [n_ch-1:0][63:0]   word,
  input  logic [n_ch-1:0][3:0]    word_len,
  input  logic [n_ch-1:0]         word_valid,
  input  logic [n_ch-1:0]         game_over,
  output logic [n_ch-1:0]         clr_word,
  output logic [n_ch-1:0]         clr_game
);

  localparam int ch_w = (n_ch > 1) ? $clog2(n_ch) : 1;

  logic            wr_rdy_q;  // awready and wready together
  logic            bvalid_q;
  logic            rvalid_q;
  logic [31:0]     rdata_q;
  logic            wr_fire;
  logic            rd_fire;
  logic [7:0]      wr_ch;
  logic [7:0]      wr_ofs;
  logic [7:0]      rd_ch;
  logic [7:0]      rd_ofs;
  logic [ch_w-1:0] wr_idx;
  logic [ch_w-1:0] rd_idx;
  logic [31:0]     rd_val;

  assign wr_fire = wr_rdy_q && s_axil.awvalid && s_axil.wvalid;
  assign rd_fire = s_axil.arvalid && !rvalid_q;

  assign wr_ch  = s_axil.awaddr / multitap_pkg::ch_stride;
  assign wr_ofs = s_axil.awaddr % multitap_pkg::ch_stride;
  assign rd_ch  = s_axil.araddr / multitap_pkg::ch_stride;
  assign rd_ofs = s_axil.araddr % multitap_pkg::ch_stride;
  assign wr_idx = wr_ch[ch_w-1:0];
  assign rd_idx = rd_ch[ch_w-1:0];

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      wr_rdy_q <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // Both channels valid and no B pending
      wr_rdy_q <= !wr_rdy_q && s_axil.awvalid && s_axil.wvalid && !bvalid_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (s_axil.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (s_axil.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= rd_val; // Held until rready
  end

  always_comb begin
    rd_val = 32'd0; // Unmapped reads as zero
    if (int'(rd_ch) < n_ch) begin
      case (rd_ofs)
        multitap_pkg::reg_status:
          rd_val = {20'd0, word_len[rd_idx], 6'd0, game_over[rd_idx], word_valid[rd_idx]};
        multitap_pkg::reg_word_lo: rd_val = word[rd_idx][31:0];
        multitap_pkg::reg_word_hi: rd_val = word[rd_idx][63:32];
        default:                   rd_val = 32'd0;
      endcase
    end
  end

  // Write-1-to-clear on the status register, byte 0 only
  always_comb begin
    clr_word = '0;
    clr_game = '0;
    if (wr_fire && s_axil.wstrb[0] && (wr_ofs == multitap_pkg::reg_status) &&
        (int'(wr_ch) < n_ch)) begin
      clr_word[wr_idx] = s_axil.wdata[0];
      clr_game[wr_idx] = s_axil.wdata[1];
    end
  end

  always_comb begin
    s_axil_rsp.awready = wr_rdy_q;
    s_axil_rsp.wready  = wr_rdy_q;
    s_axil_rsp.bresp   = multitap_pkg::resp_okay;
    s_axil_rsp.bvalid  = bvalid_q;
    s_axil_rsp.arready = !rvalid_q;
    s_axil_rsp.rdata   = rdata_q;
    s_axil_rsp.rresp   = multitap_pkg::resp_okay;
    s_axil_rsp.rvalid  = rvalid_q;
  end

  a_rdata_hold: assert property (@(posedge clk) disable iff (!nRst)
    s_axil_rsp.rvalid && !s_axil.rready |=> s_axil_rsp.rvalid && $stable(s_axil_rsp.rdata))
    else $error("read data changed while stalled");

endmodule

/* src/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler #(
  parameter int n_ch = 4
) (
  input  logic                                  clk,
  input  logic                                  nRst,
  input  multitap_pkg::keypad_out_t [n_ch-1:0]  kp_out,
  input  logic [n_ch-1:0]                       clr_word,
  input  logic [n_ch-1:0]                       clr_game,
  output logic [n_ch-1:0][63:0]                 word,
  output logic [n_ch-1:0][3:0]                  word_len,
  output logic [n_ch-1:0]                       word_valid,
  output logic [n_ch-1:0]                       game_over
);

  // Working buffer, character 0 in byte 0
  logic [n_ch-1:0][7:0][7:0] work_buf;
  logic [n_ch-1:0][3:0]      buf_len;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      work_buf   <= '0;
      buf_len    <= '0;
      word       <= '0;
      word_len   <= '0;
      word_valid <= '0;
      game_over  <= '0;
    end else begin
      for (int i = 0; i < n_ch; i++) begin
        if (kp_out[i].word_submit) begin
          word[i]     <= work_buf[i];
          word_len[i] <= buf_len[i];
          work_buf[i] <= '0;
          buf_len[i]  <= 4'd0;
        end else if (kp_out[i].game_end) begin
          work_buf[i] <= '0;
          buf_len[i]  <= 4'd0;
        end else if (kp_out[i].letter_ready && (buf_len[i] < multitap_pkg::max_letters)) begin
          work_buf[i][buf_len[i][2:0]] <= kp_out[i].letter;
          buf_len[i]                   <= buf_len[i] + 4'd1;
        end
        // Letters past the eighth fall through unused

        // Set beats clear in the same cycle
        if (kp_out[i].word_submit) begin
          word_valid[i] <= 1'b1;
        end else if (clr_word[i]) begin
          word_valid[i] <= 1'b0;
        end

        if (kp_out[i].game_end) begin
          game_over[i] <= 1'b1; // Sticky until the host clears it
        end else if (clr_game[i]) begin
          game_over[i] <= 1'b0;
        end
      end
    end
  end

endmodule

/* src/keypad_fsm.sv */
`timescale 1ns/1ps

module keypad_fsm (
  input  logic                      clk,
  input  logic                      nRst,
  input  multitap_pkg::key_event_t  key_evt,
  output multitap_pkg::keypad_out_t kp_out
);

  localparam logic [7:0] letter_blank = 8'h5F; // Underscore

  multitap_pkg::tap_state_t state;
  multitap_pkg::tap_state_t next_state;
  logic [7:0] last_key;
  logic [7:0] next_last_key;
  logic [7:0] letter;
  logic [7:0] next_letter;
  logic       letter_ready;
  logic       word_submit;
  logic       game_end;

  function automatic logic is_letter(input logic [7:0] code);
    return code inside {multitap_pkg::key_2, multitap_pkg::key_3, multitap_pkg::key_4,
                        multitap_pkg::key_5, multitap_pkg::key_6, multitap_pkg::key_7,
                        multitap_pkg::key_8, multitap_pkg::key_9};
  endfunction

  function automatic logic is_tap(input multitap_pkg::tap_state_t st);
    return st inside {multitap_pkg::st_tap1, multitap_pkg::st_tap2,
                      multitap_pkg::st_tap3, multitap_pkg::st_tap4};
  endfunction

  // First letter printed on each key
  function automatic logic [7:0] base_letter(input logic [7:0] code);
    case (code)
      multitap_pkg::key_2: return "A";
      multitap_pkg::key_3: return "D";
      multitap_pkg::key_4: return "G";
      multitap_pkg::key_5: return "J";
      multitap_pkg::key_6: return "M";
      multitap_pkg::key_7: return "P";
      multitap_pkg::key_8: return "T";
      multitap_pkg::key_9: return "W";
      default:             return 8'h00;
    endcase
  endfunction

  function automatic logic [7:0] tap_offset(input multitap_pkg::tap_state_t st);
    case (st)
      multitap_pkg::st_tap2: return 8'd1;
      multitap_pkg::st_tap3: return 8'd2;
      multitap_pkg::st_tap4: return 8'd3;
      default:               return 8'd0;
    endcase
  endfunction

  // Another tap on the same key
  function automatic multitap_pkg::tap_state_t next_tap(input multitap_pkg::tap_state_t st,
                                                        input logic [7:0] code);
    logic four;
    four = (code == multitap_pkg::key_7) || (code == multitap_pkg::key_9);
    case (st)
      multitap_pkg::st_tap1: return multitap_pkg::st_tap2;
      multitap_pkg::st_tap2: return multitap_pkg::st_tap3;
      multitap_pkg::st_tap3: return four ? multitap_pkg::st_tap4 : multitap_pkg::st_tap1;
      default:               return multitap_pkg::st_tap1; // Wrap from tap4
    endcase
  endfunction

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state    <= multitap_pkg::st_idle;
      last_key <= 8'h00;
      letter   <= letter_blank;
    end else begin
      state    <= next_state;
      last_key <= next_last_key;
      letter   <= next_letter;
    end
  end

  always_comb begin
    next_state    = state;
    next_last_key = last_key;
    next_letter   = letter;
    letter_ready  = 1'b0;
    word_submit   = 1'b0;
    game_end      = 1'b0;

    if (state == multitap_pkg::st_done) next_state = multitap_pkg::st_idle;

    if (key_evt.press) begin
      if (is_letter(key_evt.code)) begin
        if ((key_evt.code == last_key) && is_tap(state)) begin
          next_state = next_tap(state, key_evt.code);
        end else begin
          next_state = multitap_pkg::st_tap1; // New key starts over
        end
        next_last_key = key_evt.code; // Only letter keys are remembered
        next_letter   = base_letter(key_evt.code) + tap_offset(next_state);
      end else begin
        case (key_evt.code)
          multitap_pkg::key_submit_letter: begin
            if (is_tap(state)) begin // Nothing pending in idle
              letter_ready = 1'b1;
              next_state   = multitap_pkg::st_done;
              next_letter  = letter_blank;
            end
          end
          multitap_pkg::key_clear: begin
            next_state  = multitap_pkg::st_idle;
            next_letter = letter_blank;
          end
          multitap_pkg::key_submit_word: begin
            word_submit = 1'b1;
            next_state  = multitap_pkg::st_idle;
            next_letter = 8'h00;
          end
          multitap_pkg::key_game_end: begin
            game_end    = 1'b1;
            next_state  = multitap_pkg::st_idle;
            next_letter = 8'h00;
          end
          multitap_pkg::key_1, multitap_pkg::key_a,
          multitap_pkg::key_b, multitap_pkg::key_d: ; // Dead keys
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    kp_out.letter       = letter; // Pending letter, sampled with letter_ready
    kp_out.letter_ready = letter_ready;
    kp_out.word_submit  = word_submit;
    kp_out.game_end     = game_end;
  end

  // One pulse per press, and presses from the sync stage are never back to back
  a_single_pulse: assert property (@(posedge clk) disable iff (!nRst)
    $onehot0({letter_ready, word_submit, game_end}) &&
    !((|{letter_ready, word_submit, game_end}) &&
      (|$past({letter_ready, word_submit, game_end}))))
    else $error("overlapping keypad output pulses");

endmodule

/* src/key_strobe_sync.sv */
`timescale 1ns/1ps

module key_strobe_sync #(
  parameter int n_ch = 4
) (
  input  logic                                 clk,
  input  logic                                 nRst,
  input  logic [n_ch-1:0][7:0]                 key_raw,
  output multitap_pkg::key_event_t [n_ch-1:0]  key_evt
);

  logic [n_ch-1:0][7:0] sync_q1;
  logic [n_ch-1:0][7:0] sync_q2;
  logic [n_ch-1:0]      any_q;   // Some key was down last cycle

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      any_q   <= '0;
    end else begin
      sync_q1 <= key_raw;
      sync_q2 <= sync_q1;
      for (int i = 0; i < n_ch; i++) begin
        any_q[i] <= |sync_q2[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < n_ch; i++) begin
      key_evt[i].code  = sync_q2[i];
      key_evt[i].press = (|sync_q2[i]) && !any_q[i]; // Rising edge of any key
    end
  end

  for (genvar g = 0; g < n_ch; g++) begin : g_chk
    // A press only follows a cycle with no key down
    a_press_edge: assert property (@(posedge clk) disable iff (!nRst)
      key_evt[g].press |-> (key_evt[g].code != 8'h00) && ($past(key_evt[g].code) == 8'h00))
      else $error("press without a fresh key on channel %0d", g);
  end

endmodule

/* src/multitap_pkg.sv */
package multitap_pkg;

  // Upper nibble is the one-hot row, lower nibble the one-hot column
  localparam logic [7:0] key_2 = 8'h84; // R0 C1
  localparam logic [7:0] key_3 = 8'h82; // R0 C2
  localparam logic [7:0] key_4 = 8'h48; // R1 C0
  localparam logic [7:0] key_5 = 8'h44; // R1 C1
  localparam logic [7:0] key_6 = 8'h42; // R1 C2
  localparam logic [7:0] key_7 = 8'h28; // R2 C0, four letters
  localparam logic [7:0] key_8 = 8'h24; // R2 C1
  localparam logic [7:0] key_9 = 8'h22; // R2 C2, four letters

  localparam logic [7:0] key_submit_letter = 8'h18; // R3 C0
  localparam logic [7:0] key_clear         = 8'h14; // R3 C1
  localparam logic [7:0] key_submit_word   = 8'h12; // R3 C2
  localparam logic [7:0] key_game_end      = 8'h21; // R2 C3

  // No function assigned
  localparam logic [7:0] key_1 = 8'h88; // R0 C0
  localparam logic [7:0] key_a = 8'h81; // R0 C3
  localparam logic [7:0] key_b = 8'h41; // R1 C3
  localparam logic [7:0] key_d = 8'h11; // R3 C3

  localparam logic [3:0] max_letters = 4'd8;
  localparam logic [7:0] ch_stride   = 8'd16; // Bytes per channel
  localparam logic [7:0] reg_status  = 8'd0;
  localparam logic [7:0] reg_word_lo = 8'd4;
  localparam logic [7:0] reg_word_hi = 8'd8;
  localparam logic [1:0] resp_okay   = 2'b00;

  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_tap1  = 3'd1,
    st_tap2  = 3'd2,
    st_tap3  = 3'd3,
    st_tap4  = 3'd4,
    st_done  = 3'd5
  } tap_state_t;

  typedef struct packed {
    logic [7:0] code;
    logic       press; // Single cycle, first cycle of a press
  } key_event_t;

  typedef struct packed {
    logic [7:0] letter;
    logic       letter_ready;
    logic       word_submit;
    logic       game_end;
  } keypad_out_t;

  typedef struct packed {
    logic [7:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

endpackage
